// ==== project.f ====
common/exe_pkg.sv
common/exe_inst_if.sv
alu/exe_alu.sv
lsu/mem_align.sv
lsu/dmem_request.sv
design/exe_stage_reg.sv
design/exe_stage.sv
dv/exe_stage_checker.sv
dv/tb_exe_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_exe_stage \
  -Mdir obj_dir -o sim_exe_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_exe_stage +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== dv/tb_exe_stage.sv ====
`timescale 1ns/1ps

module tb_exe_stage;

  localparam int N_TESTS     = 5;
  localparam int N_PER_TEST  = 60;
  localparam int CYCLE_LIMIT = 8 + 40 * N_TESTS * N_PER_TEST;

  typedef struct packed {
    exe_pkg::alu_op_t   op;
    exe_pkg::src1_sel_t src1;
    exe_pkg::src2_sel_t src2;
    logic               may_ov;
    logic               load;
    logic               store;
    exe_pkg::mem_size_t size;
    logic               gr_we;
    exe_pkg::reg_idx_t  dest;
    exe_pkg::imm_t      imm;
    exe_pkg::word_t     rs;
    exe_pkg::word_t     rt;
    exe_pkg::word_t     pc;
  } item_t;

  typedef struct packed {
    exe_pkg::word_t     result;
    logic               adel;
    logic               ades;
    logic               ov;
    exe_pkg::reg_idx_t  dest;
    logic               gr_we;
    logic               load;
    exe_pkg::mem_size_t size;
    exe_pkg::word_t     pc;
    logic               has_req; // aligned load/store without overflow
    logic               wr;
    exe_pkg::strb_t     wstrb;
    exe_pkg::word_t     addr;
    exe_pkg::word_t     wdata;
  } exp_t;

  logic clk;
  logic reset;
  logic in_valid, in_may_overflow, in_load, in_store, in_gr_we;
  exe_pkg::alu_op_t   in_alu_op;
  exe_pkg::src1_sel_t in_src1_sel;
  exe_pkg::src2_sel_t in_src2_sel;
  exe_pkg::mem_size_t in_mem_size, out_mem_size, data_size;
  exe_pkg::reg_idx_t  in_dest, out_dest;
  exe_pkg::imm_t      in_imm;
  exe_pkg::word_t     in_rs_value, in_rt_value, in_pc, out_result, out_pc, data_addr, data_wdata;
  exe_pkg::strb_t     data_wstrb;
  logic allowin, out_valid, out_gr_we, out_load, out_exc_adel, out_exc_ades, out_exc_ov;
  logic out_ready, data_req, data_wr, data_addr_ok;

  item_t       stim_q[$];
  exp_t        exp_q[$];
  exp_t        req_q[$];
  logic [31:0] lfsr = 32'h6d71_8f47;
  int          taking;  // item enters the stage at the coming edge
  int          errors = 0;
  int          checks = 0;
  int          issued = 0;
  int          cycles;

  exe_stage i_exe_stage (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic rand_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
      r = {r[30:0], rand_bit()};
    return r;
  endfunction

  // address is rs + sext(imm) with the low bits of the sum taken from off
  function automatic item_t set_mem(input item_t it, input logic [1:0] off);
    item_t m;
    m = it;
    m.op    = exe_pkg::alu_op_t'(12'b1 << exe_pkg::ALU_ADD);
    m.src1  = exe_pkg::SRC1_RS;
    m.src2  = exe_pkg::SRC2_IMM_SEXT;
    m.rs    = rand_bits(32) & 32'hffff_fffc;
    m.imm   = {14'(rand_bits(14)), off};
    m.load  = rand_bit();
    m.store = !m.load;
    return m;
  endfunction

  function automatic item_t make_item(input int t);
    item_t      it;
    logic [1:0] off;
    it.op     = exe_pkg::alu_op_t'(12'b1 << (rand_bits(4) % 12));
    it.src1   = 2'(rand_bits(2) % 3);
    it.src2   = 2'(rand_bits(2));
    it.may_ov = 1'b0;
    it.load   = 1'b0;
    it.store  = 1'b0;
    it.size   = 2'(rand_bits(2) % 3);
    it.gr_we  = rand_bit();
    it.dest   = 5'(rand_bits(5));
    it.imm    = 16'(rand_bits(16));
    it.rs     = rand_bits(32);
    it.rt     = rand_bits(32);
    it.pc     = rand_bits(32) & 32'hffff_fffc;
    off       = 2'(rand_bits(2));
    case (t)
      1:
      begin
        it.op     = exe_pkg::alu_op_t'(12'b1 << (rand_bit() ? exe_pkg::ALU_SUB : exe_pkg::ALU_ADD));
        it.src1   = exe_pkg::SRC1_RS;
        it.src2   = exe_pkg::SRC2_RT;
        it.may_ov = rand_bit();
      end
      2:
      begin
        if (it.size == exe_pkg::SIZE_HALF)
          off[0] = 1'b0;
        else if (it.size == exe_pkg::SIZE_WORD)
          off = 2'b00;
        it = set_mem(it, off);
      end
      3:
      begin
        it.size = rand_bit() ? exe_pkg::SIZE_HALF : exe_pkg::SIZE_WORD;
        if (it.size == exe_pkg::SIZE_HALF)
          off[0] = 1'b1;
        else if (off == 2'b00)
          off = 2'b11;
        it = set_mem(it, off);
      end
      4:
      begin
        it.may_ov = rand_bit();
        if (rand_bits(2) == 0) // about a quarter are memory ops
          it = set_mem(it, off);
      end
      default: ;
    endcase
    return it;
  endfunction

  function automatic exp_t ref_model(input item_t it);
    exp_t           e;
    exe_pkg::word_t a;
    exe_pkg::word_t b;
    exe_pkg::word_t r;
    logic           ov;
    logic           mis;
    int             nbytes; // bytes per access
    a  = (it.src1 == exe_pkg::SRC1_SA) ? {27'b0, it.imm[10:6]}
       : (it.src1 == exe_pkg::SRC1_PC) ? it.pc : it.rs;
    case (it.src2)
      exe_pkg::SRC2_IMM_SEXT: b = {{16{it.imm[15]}}, it.imm};
      exe_pkg::SRC2_IMM_ZEXT: b = {16'h0000, it.imm};
      exe_pkg::SRC2_EIGHT:    b = 32'd8;
      default:                b = it.rt;
    endcase
    r  = '0;
    ov = 1'b0;
    if (it.op[exe_pkg::ALU_ADD])
    begin
      r  = a + b;
      ov = (a[31] == b[31]) && (r[31] != a[31]);
    end
    else if (it.op[exe_pkg::ALU_SUB])
    begin
      r  = a - b;
      ov = (a[31] != b[31]) && (r[31] != a[31]);
    end
    else if (it.op[exe_pkg::ALU_SLT])  r = {31'b0, $signed(a) < $signed(b)};
    else if (it.op[exe_pkg::ALU_SLTU]) r = {31'b0, a < b};
    else if (it.op[exe_pkg::ALU_AND])  r = a & b;
    else if (it.op[exe_pkg::ALU_NOR])  r = ~(a | b);
    else if (it.op[exe_pkg::ALU_OR])   r = a | b;
    else if (it.op[exe_pkg::ALU_XOR])  r = a ^ b;
    else if (it.op[exe_pkg::ALU_SLL])  r = b << a[4:0];
    else if (it.op[exe_pkg::ALU_SRL])  r = b >> a[4:0];
    else if (it.op[exe_pkg::ALU_SRA])  r = $signed(b) >>> a[4:0];
    else if (it.op[exe_pkg::ALU_LUI])  r = {b[15:0], 16'h0000};
    e        = '0;
    e.result = r;
    e.ov     = ov && it.may_ov;
    nbytes   = 1 << it.size;
    mis      = (r[1:0] % nbytes) != 0;
    e.adel    = it.load && mis;
    e.ades    = it.store && mis;
    e.dest    = it.dest;
    e.gr_we   = it.gr_we;
    e.load    = it.load;
    e.size    = it.size;
    e.pc      = it.pc;
    e.has_req = (it.load || it.store) && !mis && !e.ov;
    e.wr      = it.store;
    e.addr    = {r[31:2], 2'b00};
    // each lane holds the data byte at its offset within the access
    for (int i = 0; i < 4; i++)
    begin
      e.wstrb[i]        = it.store && (i / nbytes == r[1:0] / nbytes);
      e.wdata[8*i +: 8] = it.rt[8*(i % nbytes) +: 8];
    end
    return e;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_item(input item_t it);
    in_alu_op       = it.op;
    in_src1_sel     = it.src1;
    in_src2_sel     = it.src2;
    in_may_overflow = it.may_ov;
    in_load         = it.load;
    in_store        = it.store;
    in_mem_size     = it.size;
    in_gr_we        = it.gr_we;
    in_dest         = it.dest;
    in_imm          = it.imm;
    in_rs_value     = it.rs;
    in_rt_value     = it.rt;
    in_pc           = it.pc;
  endtask

  task automatic drive_loop();
    exp_t e;
    forever
    begin
      @(negedge clk);
      out_ready    = rand_bit();
      data_addr_ok = rand_bit();
      taking       = 0;
      in_valid     = (stim_q.size() != 0);
      if (in_valid)
        drive_item(stim_q[0]);
      #1;
      if (in_valid && allowin) // transfer at the next rising edge
      begin
        e = ref_model(stim_q[0]);
        exp_q.push_back(e);
        if (e.has_req)
          req_q.push_back(e);
        void'(stim_q.pop_front());
        taking = 1;
        issued++;
      end
    end
  endtask

  task automatic compare_loop();
    exp_t e;
    int   stage_items;
    forever
    begin
      @(negedge clk);
      #5;
      stage_items = exp_q.size() - taking;
      if (data_req && data_addr_ok)
      begin
        if (req_q.size() == 0)
        begin
          errors++;
          $display("Unexpected data request at %0t with no memory access pending", $time);
        end
        else
        begin
          e = req_q.pop_front();
          check_value("data_wr", 32'(data_wr), 32'(e.wr));
          check_value("data_size", 32'(data_size), 32'(e.size));
          check_value("data_wstrb", 32'(data_wstrb), 32'(e.wstrb));
          check_value("data_addr", data_addr, e.addr);
          if (e.wr)
            check_value("data_wdata", data_wdata, e.wdata);
        end
      end
      if (stage_items > 0 && !(out_valid && out_ready) && allowin)
      begin
        errors++;
        $display("allowin was high at %0t while the held item could not leave", $time);
      end
      if (out_valid && out_ready)
      begin
        if (stage_items == 0)
        begin
          errors++;
          $display("An item left the stage at %0t although none was issued", $time);
        end
        else
        begin
          e = exp_q.pop_front();
          check_value("out_result", out_result, e.result);
          check_value("out_exc_ov", 32'(out_exc_ov), 32'(e.ov));
          check_value("out_exc_adel", 32'(out_exc_adel), 32'(e.adel));
          check_value("out_exc_ades", 32'(out_exc_ades), 32'(e.ades));
          check_value("out_dest", 32'(out_dest), 32'(e.dest));
          check_value("out_gr_we", 32'(out_gr_we), 32'(e.gr_we));
          check_value("out_load", 32'(out_load), 32'(e.load));
          check_value("out_mem_size", 32'(out_mem_size), 32'(e.size));
          check_value("out_pc", out_pc, e.pc);
        end
      end
    end
  endtask

  function automatic string test_name(input int t);
    case (t)
      0:       return "alu_ops";
      1:       return "overflow";
      2:       return "aligned_mem";
      3:       return "misaligned";
      default: return "mixed";
    endcase
  endfunction

  initial
  begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Checks failed");
    $finish;
  end

  initial
  begin : main
    int err_start;
    int total_fails;
    reset        = 1'b1;
    taking       = 0;
    out_ready    = 1'b0;
    data_addr_ok = 1'b0;
    in_valid     = 1'b0;
    drive_item('0);
    repeat (8) @(negedge clk);
    reset = 1'b0;
    fork
      drive_loop();
      compare_loop();
    join_none
    for (int t = 0; t < N_TESTS; t++)
    begin
      err_start = errors;
      for (int i = 0; i < N_PER_TEST; i++)
        stim_q.push_back(make_item(t));
      while (stim_q.size() != 0 || exp_q.size() != 0)
      begin
        @(negedge clk);
        #8;
      end
      if (req_q.size() != 0)
      begin
        errors++;
        $display("%0d expected data requests were never issued", req_q.size());
        req_q.delete();
      end
      $display("test %0d %s: %0d items, %0d errors", t, test_name(t), N_PER_TEST,
               errors - err_start);
    end
    total_fails = errors + i_exe_stage.i_checker.fail_count;
    $display("summary: %0d items, %0d checks, %0d errors, %0d assertion failures",
             issued, checks, errors, i_exe_stage.i_checker.fail_count);
    if (total_fails == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== dv/exe_stage_checker.sv ====
`timescale 1ns/1ps

module exe_stage_checker
(
  input logic                clk,
  input logic                reset,
  input logic                out_valid,
  input logic                out_ready,
  input exe_pkg::word_t      out_result,
  input exe_pkg::reg_idx_t   out_dest,
  input logic                out_gr_we,
  input logic                out_load,
  input exe_pkg::mem_size_t  out_mem_size,
  input exe_pkg::word_t      out_pc,
  input logic                out_exc_adel,
  input logic                out_exc_ades,
  input logic                out_exc_ov,
  input logic                data_req,
  input logic                data_wr,
  input exe_pkg::mem_size_t  data_size,
  input exe_pkg::strb_t      data_wstrb,
  input exe_pkg::word_t      data_addr,
  input exe_pkg::word_t      data_wdata,
  input logic                data_addr_ok
);

  int fail_count = 0; // read by the testbench summary

  req_hold: assert property (@(posedge clk) disable iff (reset)
      data_req && !data_addr_ok |=> data_req
        && $stable({data_wr, data_size, data_wstrb, data_addr, data_wdata}))
    else
    begin
      $error("data request dropped or changed before data_addr_ok");
      fail_count++;
    end

  out_hold: assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid
        && $stable({out_result, out_dest, out_gr_we, out_load, out_mem_size, out_pc,
                    out_exc_adel, out_exc_ades, out_exc_ov}))
    else
    begin
      $error("output item changed while stalled by out_ready");
      fail_count++;
    end

  // a write enables one lane per byte of its size, a read none
  strb_on_write: assert property (@(posedge clk) disable iff (reset)
      data_req |-> (data_wr ? ($countones(data_wstrb) == (1 << data_size))
                            : (data_wstrb == 4'b0000)))
    else
    begin
      $error("write strobe does not match the request");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clk) reset |=> !out_valid && !data_req)
    else
    begin
      $error("out_valid or data_req high right after reset");
      fail_count++;
    end

endmodule

bind exe_stage exe_stage_checker i_checker (
  .clk          (clk),
  .reset        (reset),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .out_result   (out_result),
  .out_dest     (out_dest),
  .out_gr_we    (out_gr_we),
  .out_load     (out_load),
  .out_mem_size (out_mem_size),
  .out_pc       (out_pc),
  .out_exc_adel (out_exc_adel),
  .out_exc_ades (out_exc_ades),
  .out_exc_ov   (out_exc_ov),
  .data_req     (data_req),
  .data_wr      (data_wr),
  .data_size    (data_size),
  .data_wstrb   (data_wstrb),
  .data_addr    (data_addr),
  .data_wdata   (data_wdata),
  .data_addr_ok (data_addr_ok)
);

// ==== design/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage
(
  input  logic                clk,
  input  logic                reset,
  // decode side
  input  logic                in_valid,
  input  exe_pkg::alu_op_t    in_alu_op,
  input  exe_pkg::src1_sel_t  in_src1_sel,
  input  exe_pkg::src2_sel_t  in_src2_sel,
  input  logic                in_may_overflow,
  input  logic                in_load,
  input  logic                in_store,
  input  exe_pkg::mem_size_t  in_mem_size,
  input  logic                in_gr_we,
  input  exe_pkg::reg_idx_t   in_dest,
  input  exe_pkg::imm_t       in_imm,
  input  exe_pkg::word_t      in_rs_value,
  input  exe_pkg::word_t      in_rt_value,
  input  exe_pkg::word_t      in_pc,
  output logic                allowin,
  // memory stage side
  output logic                out_valid,
  output exe_pkg::word_t      out_result,
  output exe_pkg::reg_idx_t   out_dest,
  output logic                out_gr_we,
  output logic                out_load,
  output exe_pkg::mem_size_t  out_mem_size,
  output exe_pkg::word_t      out_pc,
  output logic                out_exc_adel,
  output logic                out_exc_ades,
  output logic                out_exc_ov,
  input  logic                out_ready,
  // data memory side
  output logic                data_req,
  output logic                data_wr,
  output exe_pkg::mem_size_t  data_size,
  output exe_pkg::strb_t      data_wstrb,
  output exe_pkg::word_t      data_addr,
  output exe_pkg::word_t      data_wdata,
  input  logic                data_addr_ok
);

  exe_inst_if inst_bus ();

  logic ready_go;
  logic access;      // load/store without exception
  logic item_leaves; // output handshake completes

  assign item_leaves = out_valid & out_ready;

  exe_stage_reg i_stage_reg (
    .clk             (clk),
    .reset           (reset),
    .in_valid        (in_valid),
    .in_alu_op       (in_alu_op),
    .in_src1_sel     (in_src1_sel),
    .in_src2_sel     (in_src2_sel),
    .in_may_overflow (in_may_overflow),
    .in_load         (in_load),
    .in_store        (in_store),
    .in_mem_size     (in_mem_size),
    .in_gr_we        (in_gr_we),
    .in_dest         (in_dest),
    .in_imm          (in_imm),
    .in_rs_value     (in_rs_value),
    .in_rt_value     (in_rt_value),
    .in_pc           (in_pc),
    .ready_go        (ready_go),
    .out_ready       (out_ready),
    .allowin         (allowin),
    .out_valid       (out_valid),
    .inst            (inst_bus.stage)
  );

  exe_alu i_alu (
    .inst   (inst_bus.alu),
    .result (out_result),
    .exc_ov (out_exc_ov)
  );

  mem_align i_mem_align (
    .inst       (inst_bus.lsu),
    .addr       (out_result), // alu result is the load/store address
    .exc_ov     (out_exc_ov),
    .exc_adel   (out_exc_adel),
    .exc_ades   (out_exc_ades),
    .access     (access),
    .data_size  (data_size),
    .data_wstrb (data_wstrb),
    .data_addr  (data_addr),
    .data_wdata (data_wdata)
  );

  dmem_request i_dmem_request (
    .clk          (clk),
    .reset        (reset),
    .inst         (inst_bus.lsu),
    .access       (access),
    .item_leaves  (item_leaves),
    .data_addr_ok (data_addr_ok),
    .data_req     (data_req),
    .data_wr      (data_wr),
    .ready_go     (ready_go)
  );

  assign out_dest     = inst_bus.dest;
  assign out_gr_we    = inst_bus.gr_we;
  assign out_load     = inst_bus.load;
  assign out_mem_size = inst_bus.mem_size;
  assign out_pc       = inst_bus.pc;

endmodule

// ==== design/exe_stage_reg.sv ====
`timescale 1ns/1ps

module exe_stage_reg
(
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  input  exe_pkg::alu_op_t    in_alu_op,
  input  exe_pkg::src1_sel_t  in_src1_sel,
  input  exe_pkg::src2_sel_t  in_src2_sel,
  input  logic                in_may_overflow,
  input  logic                in_load,
  input  logic                in_store,
  input  exe_pkg::mem_size_t  in_mem_size,
  input  logic                in_gr_we,
  input  exe_pkg::reg_idx_t   in_dest,
  input  exe_pkg::imm_t       in_imm,
  input  exe_pkg::word_t      in_rs_value,
  input  exe_pkg::word_t      in_rt_value,
  input  exe_pkg::word_t      in_pc,
  input  logic                ready_go,
  input  logic                out_ready,
  output logic                allowin,
  output logic                out_valid,
  exe_inst_if.stage           inst
);

  logic valid_q; // stage occupied

  // empty or the current item leaves this cycle
  assign allowin   = !valid_q || (ready_go && out_ready);
  assign out_valid = valid_q && ready_go;

  assign inst.inst_valid = valid_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_q <= 1'b0;
    end
    else if (allowin)
    begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_valid && allowin) // payload only on transfer
    begin
      inst.alu_op       <= in_alu_op;
      inst.src1_sel     <= in_src1_sel;
      inst.src2_sel     <= in_src2_sel;
      inst.may_overflow <= in_may_overflow;
      inst.load         <= in_load;
      inst.store        <= in_store;
      inst.mem_size     <= in_mem_size;
      inst.gr_we        <= in_gr_we;
      inst.dest         <= in_dest;
      inst.imm          <= in_imm;
      inst.rs_value     <= in_rs_value;
      inst.rt_value     <= in_rt_value;
      inst.pc           <= in_pc;
    end
  end

endmodule

// ==== lsu/dmem_request.sv ====
`timescale 1ns/1ps

module dmem_request
(
  input  logic      clk,
  input  logic      reset,
  exe_inst_if.lsu   inst,
  input  logic      access,
  input  logic      item_leaves,
  input  logic      data_addr_ok,
  output logic      data_req,
  output logic      data_wr,
  output logic      ready_go
);

  exe_pkg::req_state_e state;
  exe_pkg::req_state_e state_next;
  logic                need_req; // item wants a memory access
  logic                accepted; // request taken this cycle

  assign need_req = inst.inst_valid & access;
  assign data_req = need_req && (state != exe_pkg::REQ_DONE);
  assign data_wr  = inst.store;
  assign accepted = data_req & data_addr_ok;

  // non-access items pass in one cycle
  assign ready_go = !need_req || accepted || (state == exe_pkg::REQ_DONE);

  always_comb
  begin
    state_next = state;
    case (state)
      exe_pkg::REQ_IDLE,
      exe_pkg::REQ_WAIT:
      begin
        if (accepted)
          state_next = item_leaves ? exe_pkg::REQ_IDLE : exe_pkg::REQ_DONE;
        else if (data_req)
          state_next = exe_pkg::REQ_WAIT;
      end
      exe_pkg::REQ_DONE:
      begin
        if (item_leaves)
          state_next = exe_pkg::REQ_IDLE; // back-pressure released
      end
      default: state_next = exe_pkg::REQ_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= exe_pkg::REQ_IDLE;
    else
      state <= state_next;
  end

endmodule

// ==== lsu/mem_align.sv ====
`timescale 1ns/1ps

module mem_align
(
  exe_inst_if.lsu             inst,
  input  exe_pkg::word_t      addr,
  input  logic                exc_ov,
  output logic                exc_adel,
  output logic                exc_ades,
  output logic                access,
  output exe_pkg::mem_size_t  data_size,
  output exe_pkg::strb_t      data_wstrb,
  output exe_pkg::word_t      data_addr,
  output exe_pkg::word_t      data_wdata
);

  logic           misaligned;
  exe_pkg::strb_t lane_strb; // strobe before store gating

  assign misaligned = ((inst.mem_size == exe_pkg::SIZE_HALF) && addr[0])
                   || ((inst.mem_size == exe_pkg::SIZE_WORD) && (addr[1:0] != 2'b00));

  assign exc_adel = inst.load  & misaligned;
  assign exc_ades = inst.store & misaligned;

  // any exception cancels the memory access
  assign access = (inst.load | inst.store) & ~misaligned & ~exc_ov;

  assign data_size = inst.mem_size;
  assign data_addr = {addr[31:2], 2'b00};

  always_comb
  begin
    case (inst.mem_size)
      exe_pkg::SIZE_BYTE: lane_strb = 4'b0001 << addr[1:0];
      exe_pkg::SIZE_HALF: lane_strb = addr[1] ? 4'b1100 : 4'b0011;
      default:            lane_strb = 4'b1111;
    endcase
  end

  assign data_wstrb = (access && inst.store) ? lane_strb : 4'b0000;

  // replicate so every lane the strobe picks holds the data
  always_comb
  begin
    case (inst.mem_size)
      exe_pkg::SIZE_BYTE: data_wdata = {4{inst.rt_value[7:0]}};
      exe_pkg::SIZE_HALF: data_wdata = {2{inst.rt_value[15:0]}};
      default:            data_wdata = inst.rt_value;
    endcase
  end

endmodule

// ==== alu/exe_alu.sv ====
`timescale 1ns/1ps

module exe_alu
(
  exe_inst_if.alu         inst,
  output exe_pkg::word_t  result,
  output logic            exc_ov
);

  exe_pkg::word_t src1;
  exe_pkg::word_t src2;
  exe_pkg::word_t add_b;    // src2 inverted for subtract and compare
  exe_pkg::word_t sum;
  exe_pkg::word_t slt_res;
  exe_pkg::word_t sltu_res;
  logic           carry;
  logic           use_sub;
  logic           overflow;
  logic [4:0]     shamt;

  always_comb
  begin
    case (inst.src1_sel)
      exe_pkg::SRC1_SA: src1 = {27'b0, inst.imm[10:6]};
      exe_pkg::SRC1_PC: src1 = inst.pc;
      default:          src1 = inst.rs_value;
    endcase
  end

  always_comb
  begin
    case (inst.src2_sel)
      exe_pkg::SRC2_IMM_SEXT: src2 = {{16{inst.imm[15]}}, inst.imm};
      exe_pkg::SRC2_IMM_ZEXT: src2 = {16'b0, inst.imm};
      exe_pkg::SRC2_EIGHT:    src2 = 32'd8;
      default:                src2 = inst.rt_value;
    endcase
  end

  // one adder shared by add, sub, slt and sltu
  assign use_sub = inst.alu_op[exe_pkg::ALU_SUB] | inst.alu_op[exe_pkg::ALU_SLT]
                 | inst.alu_op[exe_pkg::ALU_SLTU];
  assign add_b = use_sub ? ~src2 : src2;
  assign {carry, sum} = {1'b0, src1} + {1'b0, add_b} + {32'b0, use_sub};

  // signed less-than when signs differ or the difference is negative
  assign slt_res  = {31'b0, (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & sum[31])};
  assign sltu_res = {31'b0, ~carry}; // borrow out

  // operands agree in sign but the sum does not
  assign overflow = (src1[31] == add_b[31]) && (sum[31] != src1[31]);
  assign exc_ov   = inst.may_overflow & overflow
                  & (inst.alu_op[exe_pkg::ALU_ADD] | inst.alu_op[exe_pkg::ALU_SUB]);

  assign shamt = src1[4:0];

  assign result =
      ({32{inst.alu_op[exe_pkg::ALU_ADD] | inst.alu_op[exe_pkg::ALU_SUB]}} & sum)
    | ({32{inst.alu_op[exe_pkg::ALU_SLT]}}  & slt_res)
    | ({32{inst.alu_op[exe_pkg::ALU_SLTU]}} & sltu_res)
    | ({32{inst.alu_op[exe_pkg::ALU_AND]}}  & (src1 & src2))
    | ({32{inst.alu_op[exe_pkg::ALU_NOR]}}  & ~(src1 | src2))
    | ({32{inst.alu_op[exe_pkg::ALU_OR]}}   & (src1 | src2))
    | ({32{inst.alu_op[exe_pkg::ALU_XOR]}}  & (src1 ^ src2))
    | ({32{inst.alu_op[exe_pkg::ALU_SLL]}}  & (src2 << shamt))
    | ({32{inst.alu_op[exe_pkg::ALU_SRL]}}  & (src2 >> shamt))
    | ({32{inst.alu_op[exe_pkg::ALU_SRA]}}  & 32'($signed(src2) >>> shamt))
    | ({32{inst.alu_op[exe_pkg::ALU_LUI]}}  & {src2[15:0], 16'b0});

endmodule

// ==== common/exe_inst_if.sv ====
`timescale 1ns/1ps

interface exe_inst_if;

  logic                inst_valid;   // stage holds an item
  exe_pkg::alu_op_t    alu_op;
  exe_pkg::src1_sel_t  src1_sel;
  exe_pkg::src2_sel_t  src2_sel;
  logic                may_overflow; // add/sub that traps
  logic                load;
  logic                store;
  exe_pkg::mem_size_t  mem_size;
  logic                gr_we;
  exe_pkg::reg_idx_t   dest;
  exe_pkg::imm_t       imm;
  exe_pkg::word_t      rs_value;
  exe_pkg::word_t      rt_value;
  exe_pkg::word_t      pc;

  modport stage (output inst_valid, alu_op, src1_sel, src2_sel, may_overflow, load, store,
                 mem_size, gr_we, dest, imm, rs_value, rt_value, pc);
  modport alu (input alu_op, src1_sel, src2_sel, may_overflow, imm, rs_value, rt_value, pc);
  modport lsu (input inst_valid, load, store, mem_size, rt_value);

endinterface

// ==== common/exe_pkg.sv ====
package exe_pkg;

  typedef logic [31:0] word_t;    // data or address word
  typedef logic [4:0]  reg_idx_t; // destination register number
  typedef logic [15:0] imm_t;     // instruction immediate
  typedef logic [3:0]  strb_t;    // byte write strobe

  // one-hot alu operation with one bit per op
  typedef logic [11:0] alu_op_t;

  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND  = 4;
  localparam int ALU_NOR  = 5;
  localparam int ALU_OR   = 6;
  localparam int ALU_XOR  = 7;
  localparam int ALU_SLL  = 8;
  localparam int ALU_SRL  = 9;
  localparam int ALU_SRA  = 10;
  localparam int ALU_LUI  = 11;

  typedef logic [1:0] src1_sel_t;

  localparam src1_sel_t SRC1_RS = 2'd0; // register rs
  localparam src1_sel_t SRC1_SA = 2'd1; // shift amount field
  localparam src1_sel_t SRC1_PC = 2'd2; // pc for link instructions

  typedef logic [1:0] src2_sel_t;

  localparam src2_sel_t SRC2_RT       = 2'd0; // register rt
  localparam src2_sel_t SRC2_IMM_SEXT = 2'd1; // sign-extended imm
  localparam src2_sel_t SRC2_IMM_ZEXT = 2'd2; // zero-extended imm
  localparam src2_sel_t SRC2_EIGHT    = 2'd3; // pc + 8 for links

  // values go straight out on data_size
  typedef logic [1:0] mem_size_t;

  localparam mem_size_t SIZE_BYTE = 2'd0;
  localparam mem_size_t SIZE_HALF = 2'd1;
  localparam mem_size_t SIZE_WORD = 2'd2;

  typedef enum logic [1:0] {
    REQ_IDLE, // no request sent yet
    REQ_WAIT, // request out with addr_ok pending
    REQ_DONE  // accepted while the item is held downstream
  } req_state_e;

endpackage
